/* vendingMachine.f */
+incdir+.
vendingPkg.sv
buttonConditioner.sv
ps2Receiver.sv
productKeyMapper.sv
creditController.sv
bcdFormatter.sv
sevenSegmentScan.sv
vendingMachine.sv
tb_vendingMachine.sv

/* tb_vendingMachine.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module tb_vendingMachine import vendingPkg::*;;

    localparam int DEBOUNCE_DEPTH = 4;
    localparam int REFUND_TICKS   = 40;
    localparam int SCAN_TICKS     = 4;
    localparam int NUM_ACTIONS    = 300;

    logic         clk = 1'b0;
    logic         rst_n;
    buttonSet_t   buttons;
    logic         ps2Clk;
    logic         ps2Data;
    logic [6:0]   segments;
    logic [3:0]   anodes;
    productMask_t productEnable;

    int           cycleCount = 0;
    logic [16:0]  lfsrState = 17'd69563;
    int           modelCredit = 0;
    productMask_t modelHeld = '0;

    vendingMachine #(
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH),
        .REFUND_TICKS  (REFUND_TICKS),
        .SCAN_TICKS    (SCAN_TICKS)
    ) u_vendingMachine (
        .clk          (clk),
        .rst_n        (rst_n),
        .buttons      (buttons),
        .ps2Clk       (ps2Clk),
        .ps2Data      (ps2Data),
        .segments     (segments),
        .anodes       (anodes),
        .productEnable(productEnable)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // x^17 + x^14 + 1, maximal length
    function automatic logic [16:0] lfsrNext(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic takeBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsrState[16]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEnable(input string testName, input productMask_t exp,
                               input productMask_t got);
        if (got !== exp) begin
            abortRun($sformatf("ERROR %s expected %b actual %b", testName, exp, got));
        end
    endtask

    task automatic checkDigits(input string testName, input displayDigits_t exp,
                               input displayDigits_t got);
        if (got !== exp) begin
            abortRun($sformatf("ERROR %s expected %h actual %h", testName, exp, got));
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    function automatic displayDigits_t expectedDigits(input int c);
        displayDigits_t d;
        d.d3 = DIGIT_BLANK;
        d.d2 = (c == `CREDIT_MAX) ? digitCode_t'(1) : DIGIT_BLANK;
        d.d1 = (c < 10) ? DIGIT_BLANK : digitCode_t'((c / 10) % 10);
        d.d0 = digitCode_t'(c % 10);
        return d;
    endfunction

    function automatic productMask_t expectedEnable(input int c);
        productMask_t m;
        m[0] = (c >= `PRICE_P0);
        m[1] = (c >= `PRICE_P1);
        m[2] = (c >= `PRICE_P2);
        m[3] = (c >= `PRICE_P3);
        return m;
    endfunction

    function automatic int priceOf(input int bitIndex);
        case (bitIndex)
            0:       return `PRICE_P0;
            1:       return `PRICE_P1;
            2:       return `PRICE_P2;
            default: return `PRICE_P3;
        endcase
    endfunction

    // key index 0..3 is A, S, D, F
    function automatic logic [7:0] keyCode(input int idx);
        case (idx)
            0:       return `SCAN_A;
            1:       return `SCAN_S;
            2:       return `SCAN_D;
            default: return `SCAN_F;
        endcase
    endfunction

    // segments are active low with a at bit 0
    function automatic digitCode_t segmentsToCode(input logic [6:0] seg);
        case (seg)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            7'b1111111: return DIGIT_BLANK;
            default:    return 4'hF;
        endcase
    endfunction

    task automatic readDisplay(output displayDigits_t got);
        logic [3:0] seen;
        int         waited;
        seen   = '0;
        waited = 0;
        got    = '0;
        while (seen != 4'b1111) begin
            @(negedge clk);
            waited++;
            if (waited > 8 * SCAN_TICKS + 8) begin
                abortRun("the display scan did not select all four digits in time");
            end
            case (anodes)
                4'b1110: begin
                    got.d0  = segmentsToCode(segments);
                    seen[0] = 1'b1;
                end
                4'b1101: begin
                    got.d1  = segmentsToCode(segments);
                    seen[1] = 1'b1;
                end
                4'b1011: begin
                    got.d2  = segmentsToCode(segments);
                    seen[2] = 1'b1;
                end
                4'b0111: begin
                    got.d3  = segmentsToCode(segments);
                    seen[3] = 1'b1;
                end
                4'b1111: ;
                default: abortRun("more than one anode was driven low at once");
            endcase
        end
    endtask

    task automatic checkState(input string testName);
        displayDigits_t got;
        readDisplay(got);
        checkDigits(testName, expectedDigits(modelCredit), got);
        checkEnable(testName, expectedEnable(modelCredit), productEnable);
    endtask

    task automatic pressButton(input buttonSet_t b);
        @(posedge clk);
        buttons <= b;
        waitCycles(8);
        buttons <= '0;
        waitCycles(8);
    endtask

    // start bit, 8 data bits LSB first, odd parity, stop bit
    task automatic sendFrame(input logic [7:0] code, input logic badParity);
        logic [10:0] frameBits;
        logic        parity;
        parity    = ~^code ^ badParity;
        frameBits = {1'b1, parity, code, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2Data <= frameBits[i];
            waitCycles(8);
            ps2Clk <= 1'b0;
            waitCycles(8);
            ps2Clk <= 1'b1;
        end
        ps2Data <= 1'b1;
        waitCycles(8);
    endtask

    function automatic buttonSet_t coinButton(input int sel);
        buttonSet_t b;
        b = '0;
        case (sel)
            0:       b.coinSmall = 1'b1;
            1:       b.coinMid = 1'b1;
            default: b.coinLarge = 1'b1;
        endcase
        return b;
    endfunction

    function automatic int coinValue(input int sel);
        case (sel)
            0:       return `COIN_SMALL;
            1:       return `COIN_MID;
            default: return `COIN_LARGE;
        endcase
    endfunction

    task automatic coinAction();
        int sel;
        takeBits(2, sel);
        pressButton(coinButton(sel));
        modelCredit = modelCredit + coinValue(sel);
        if (modelCredit > `CREDIT_MAX) begin
            modelCredit = `CREDIT_MAX;
        end
    endtask

    task automatic cancelAction(input int n);
        int             startCycle;
        int             startCredit;
        int             sel;
        int             target;
        int             refundStart;
        int             elapsed;
        int             steps;
        int             midCredit;
        buttonSet_t     b;
        productMask_t   mask;
        displayDigits_t got;
        startCycle  = cycleCount;
        startCredit = modelCredit;
        // debounce window, then the pulse, then the credit register
        refundStart = DEBOUNCE_DEPTH + 2;
        b           = '0;
        b.cancel    = 1'b1;
        pressButton(b);
        // zero credit leaves the machine idle
        if (startCredit != 0) begin
            @(negedge clk);
            checkEnable($sformatf("action %0d cancel clears enables", n), '0, productEnable);
            takeBits(2, sel);
            pressButton(coinButton(sel));
            takeBits(2, sel);
            mask = productMask_t'(4'b1000 >> sel);
            sendFrame(keyCode(sel), 1'b0);
            modelHeld = modelHeld | mask;
            // sample mid-step so that no decrement lands inside the display scan
            elapsed = cycleCount - startCycle - refundStart;
            while (elapsed % REFUND_TICKS != REFUND_TICKS / 4) begin
                @(posedge clk);
                elapsed = cycleCount - startCycle - refundStart;
            end
            steps     = elapsed / REFUND_TICKS;
            midCredit = startCredit - steps * `REFUND_STEP;
            if (midCredit < 0) begin
                midCredit = 0;
            end
            readDisplay(got);
            checkDigits($sformatf("action %0d refund in progress", n),
                        expectedDigits(midCredit), got);
            target = (startCredit / `REFUND_STEP) * REFUND_TICKS + 60;
            while (cycleCount - startCycle < target) begin
                @(posedge clk);
            end
            modelCredit = 0;
        end
    endtask

    task automatic keyAction();
        int           kind;
        int           idx;
        int           sub;
        logic [7:0]   code;
        productMask_t mask;
        takeBits(3, kind);
        takeBits(2, idx);
        code = keyCode(idx);
        mask = productMask_t'(4'b1000 >> idx);
        if (kind < 4) begin
            sendFrame(code, 1'b0);
            if ((mask & ~modelHeld) != '0 && modelCredit >= priceOf(3 - idx)) begin
                modelCredit = modelCredit - priceOf(3 - idx);
            end
            modelHeld = modelHeld | mask;
        end else if (kind < 6) begin
            sendFrame(`SCAN_BREAK, 1'b0);
            sendFrame(code, 1'b0);
            modelHeld = modelHeld & ~mask;
        end else if (kind == 6) begin
            // Q key, not a product
            sendFrame(8'h15, 1'b0);
        end else begin
            takeBits(1, sub);
            if (sub == 0) begin
                sendFrame(`SCAN_EXTENDED, 1'b0);
                sendFrame(code, 1'b0);
            end else begin
                // the bad frame also drops the pending break prefix
                sendFrame(`SCAN_BREAK, 1'b0);
                sendFrame(code, 1'b1);
            end
        end
    endtask

    initial begin
        repeat (NUM_ACTIONS * 2000 + 10000) @(posedge clk);
        abortRun("timeout: the test sequence did not finish in time");
    end

    initial begin
        int kind;
        rst_n   = 1'b0;
        buttons = '0;
        ps2Clk  = 1'b1;
        ps2Data = 1'b1;
        waitCycles(5);
        rst_n <= 1'b1;
        checkState("after reset");
        for (int n = 0; n < NUM_ACTIONS; n++) begin
            takeBits(3, kind);
            if (kind < 3) begin
                coinAction();
            end else if (kind == 3) begin
                cancelAction(n);
            end else begin
                keyAction();
            end
            waitCycles(12);
            checkState($sformatf("action %0d kind %0d", n, kind));
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* vendingMachine.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module vendingMachine import vendingPkg::*; #(
    parameter int DEBOUNCE_DEPTH = `DEBOUNCE_DEPTH_DEFAULT,
    parameter int REFUND_TICKS   = `REFUND_TICKS_DEFAULT,
    parameter int SCAN_TICKS     = `SCAN_TICKS_DEFAULT
) (
    input  logic         clk,
    input  logic         rst_n,
    input  buttonSet_t   buttons,
    input  logic         ps2Clk,
    input  logic         ps2Data,
    output logic [6:0]   segments,
    output logic [3:0]   anodes,
    output productMask_t productEnable
);

    buttonSet_t     pressed;
    keyEvent_t      keyEvent;
    productMask_t   buy;
    credit_t        credit;
    displayDigits_t digits;

    buttonConditioner #(
        .DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)
    ) u_buttonConditioner (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw    (buttons),
        .pressed(pressed)
    );

    ps2Receiver u_ps2Receiver (
        .clk     (clk),
        .rst_n   (rst_n),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .keyEvent(keyEvent)
    );

    productKeyMapper u_productKeyMapper (
        .clk     (clk),
        .rst_n   (rst_n),
        .keyEvent(keyEvent),
        .buy     (buy)
    );

    creditController #(
        .REFUND_TICKS(REFUND_TICKS)
    ) u_creditController (
        .clk          (clk),
        .rst_n        (rst_n),
        .pressed      (pressed),
        .buy          (buy),
        .credit       (credit),
        .productEnable(productEnable)
    );

    bcdFormatter u_bcdFormatter (
        .credit(credit),
        .digits(digits)
    );

    sevenSegmentScan #(
        .SCAN_TICKS(SCAN_TICKS)
    ) u_sevenSegmentScan (
        .clk     (clk),
        .rst_n   (rst_n),
        .digits  (digits),
        .segments(segments),
        .anodes  (anodes)
    );

endmodule

/* sevenSegmentScan.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module sevenSegmentScan import vendingPkg::*; #(
    parameter int SCAN_TICKS = `SCAN_TICKS_DEFAULT
) (
    input  logic           clk,
    input  logic           rst_n,
    input  displayDigits_t digits,
    output logic [6:0]     segments,
    output logic [3:0]     anodes
);

    localparam int TICK_W = (SCAN_TICKS > 1) ? $clog2(SCAN_TICKS) : 1;

    logic [TICK_W-1:0] tickCount;
    logic [1:0]        digitIndex;
    digitCode_t        current;
    logic [6:0]        pattern;

    always_comb begin
        case (digitIndex)
            2'd0:    current = digits.d0;
            2'd1:    current = digits.d1;
            2'd2:    current = digits.d2;
            default: current = digits.d3;
        endcase
    end

    // active low, segment a at bit 0, blank and unknown codes dark
    always_comb begin
        case (current)
            4'd0:    pattern = 7'b1000000;
            4'd1:    pattern = 7'b1111001;
            4'd2:    pattern = 7'b0100100;
            4'd3:    pattern = 7'b0110000;
            4'd4:    pattern = 7'b0011001;
            4'd5:    pattern = 7'b0010010;
            4'd6:    pattern = 7'b0000010;
            4'd7:    pattern = 7'b1111000;
            4'd8:    pattern = 7'b0000000;
            4'd9:    pattern = 7'b0010000;
            default: pattern = 7'b1111111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tickCount  <= '0;
            digitIndex <= '0;
            segments   <= 7'b1111111;
            anodes     <= 4'b1111;
        end else begin
            segments <= pattern;
            anodes   <= ~(4'b0001 << digitIndex);
            if (tickCount == TICK_W'(SCAN_TICKS - 1)) begin
                tickCount  <= '0;
                digitIndex <= digitIndex + 2'd1;
            end else begin
                tickCount <= tickCount + 1'b1;
            end
        end
    end

endmodule

/* bcdFormatter.sv */
`timescale 1ns/1ps

module bcdFormatter import vendingPkg::*; (
    input  credit_t        credit,
    output displayDigits_t digits
);

    localparam credit_t FULL = 7'd100;

    digitCode_t tens;

    // comparison chain instead of a divider
    always_comb begin
        tens = '0;
        for (int i = 1; i < 10; i++) begin
            if (credit >= credit_t'(10 * i)) begin
                tens = digitCode_t'(i);
            end
        end
    end

    always_comb begin
        // credit only moves in steps of 5
        digits.d0 = credit[0] ? 4'd5 : 4'd0;
        if (credit < 7'd10) begin
            digits.d1 = DIGIT_BLANK;
        end else if (credit == FULL) begin
            digits.d1 = 4'd0;
        end else begin
            digits.d1 = tens;
        end
        digits.d2 = (credit == FULL) ? 4'd1 : DIGIT_BLANK;
        digits.d3 = DIGIT_BLANK;
    end

endmodule

/* creditController.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module creditController import vendingPkg::*; #(
    parameter int REFUND_TICKS = `REFUND_TICKS_DEFAULT
) (
    input  logic         clk,
    input  logic         rst_n,
    input  buttonSet_t   pressed,
    input  productMask_t buy,
    output credit_t      credit,
    output productMask_t productEnable
);

    localparam int TICK_W = (REFUND_TICKS > 1) ? $clog2(REFUND_TICKS) : 1;
    localparam credit_t CAP = credit_t'(`CREDIT_MAX);
    localparam credit_t STEP = credit_t'(`REFUND_STEP);
    localparam credit_t PRICE [4] = '{
        credit_t'(`PRICE_P0),
        credit_t'(`PRICE_P1),
        credit_t'(`PRICE_P2),
        credit_t'(`PRICE_P3)
    };

    logic              refunding;
    logic [TICK_W-1:0] tickCount;
    logic [1:0]        buyIndex;
    logic              buyHit;
    credit_t           coinValue;
    logic [7:0]        coinSum;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            productEnable[i] = (credit >= PRICE[i]) && !refunding;
        end
    end

    // lowest requested product wins
    always_comb begin
        buyIndex = '0;
        buyHit   = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (buy[i]) begin
                buyIndex = 2'(i);
                buyHit   = 1'b1;
            end
        end
    end

    always_comb begin
        coinValue = '0;
        if (pressed.coinSmall) begin
            coinValue = credit_t'(`COIN_SMALL);
        end else if (pressed.coinMid) begin
            coinValue = credit_t'(`COIN_MID);
        end else if (pressed.coinLarge) begin
            coinValue = credit_t'(`COIN_LARGE);
        end
    end

    assign coinSum = {1'b0, credit} + {1'b0, coinValue};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit    <= '0;
            refunding <= 1'b0;
            tickCount <= '0;
        end else if (refunding) begin
            if (tickCount == TICK_W'(REFUND_TICKS - 1)) begin
                tickCount <= '0;
                if (credit <= STEP) begin
                    credit    <= '0;
                    refunding <= 1'b0;
                end else begin
                    credit <= credit - STEP;
                end
            end else begin
                tickCount <= tickCount + 1'b1;
            end
        end else if (buyHit) begin
            if (productEnable[buyIndex]) begin
                credit <= credit - PRICE[buyIndex];
            end
        end else if (coinValue != '0) begin
            credit <= (coinSum > {1'b0, CAP}) ? CAP : coinSum[6:0];
        end else if (pressed.cancel && credit != '0) begin
            refunding <= 1'b1;
            tickCount <= '0;
        end
    end

endmodule

/* productKeyMapper.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module productKeyMapper import vendingPkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  keyEvent_t    keyEvent,
    output productMask_t buy
);

    productMask_t keyMask;
    productMask_t held;

    // A buys the most expensive product, F the cheapest
    always_comb begin
        case (keyEvent.code)
            `SCAN_A: keyMask = 4'b1000;
            `SCAN_S: keyMask = 4'b0100;
            `SCAN_D: keyMask = 4'b0010;
            `SCAN_F: keyMask = 4'b0001;
            default: keyMask = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= '0;
            buy  <= '0;
        end else begin
            buy <= '0;
            if (keyEvent.valid && !keyEvent.extended) begin
                if (keyEvent.released) begin
                    held <= held & ~keyMask;
                end else begin
                    // typematic repeats of a held key are ignored
                    buy  <= keyMask & ~held;
                    held <= held | keyMask;
                end
            end
        end
    end

endmodule

/* ps2Receiver.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module ps2Receiver import vendingPkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ps2Clk,
    input  logic      ps2Data,
    output keyEvent_t keyEvent
);

    logic [1:0]  clkSync;
    logic [1:0]  dataSync;
    logic        clkPrev;
    logic        fallEdge;
    logic [10:0] frame;
    logic [3:0]  bitCount;
    logic        frameDone;
    logic        parityOk;
    logic        byteReady;
    logic        frameBad;
    logic [7:0]  byteData;
    logic        breakFlag;
    logic        extFlag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clkSync  <= 2'b11;
            dataSync <= 2'b11;
            clkPrev  <= 1'b1;
        end else begin
            clkSync  <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkPrev  <= clkSync[1];
        end
    end

    assign fallEdge = clkPrev & ~clkSync[1];

    // bits arrive LSB first, so the stop bit ends up in frame[10]
    always_ff @(posedge clk) begin
        if (fallEdge) begin
            frame <= {dataSync[1], frame[10:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bitCount  <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            if (fallEdge) begin
                if (bitCount == 4'd10) begin
                    bitCount  <= '0;
                    frameDone <= 1'b1;
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end
        end
    end

    // odd parity over data and parity bit
    assign parityOk = ^frame[9:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byteReady <= 1'b0;
            frameBad  <= 1'b0;
        end else begin
            byteReady <= frameDone & parityOk & frame[10];
            frameBad  <= frameDone & ~(parityOk & frame[10]);
        end
    end

    always_ff @(posedge clk) begin
        if (frameDone) begin
            byteData <= frame[8:1];
        end
    end

    // prefixes only set flags, the next code byte carries them out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            breakFlag <= 1'b0;
            extFlag   <= 1'b0;
            keyEvent  <= '0;
        end else begin
            keyEvent.valid <= 1'b0;
            if (frameBad) begin
                breakFlag <= 1'b0;
                extFlag   <= 1'b0;
            end else if (byteReady) begin
                if (byteData == `SCAN_BREAK) begin
                    breakFlag <= 1'b1;
                end else if (byteData == `SCAN_EXTENDED) begin
                    extFlag <= 1'b1;
                end else begin
                    keyEvent.valid    <= 1'b1;
                    keyEvent.released <= breakFlag;
                    keyEvent.extended <= extFlag;
                    keyEvent.code     <= byteData;
                    breakFlag         <= 1'b0;
                    extFlag           <= 1'b0;
                end
            end
        end
    end

endmodule

/* buttonConditioner.sv */
`timescale 1ns/1ps
`include "vendingMachine_cfg.svh"

module buttonConditioner import vendingPkg::*; #(
    parameter int DEBOUNCE_DEPTH = `DEBOUNCE_DEPTH_DEFAULT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  buttonSet_t raw,
    output buttonSet_t pressed
);

    logic [3:0]                rawBits;
    logic [3:0]                filtered;
    logic [3:0]                filteredDly;
    logic [3:0]                pulse;
    logic [DEBOUNCE_DEPTH-1:0] history [4];

    assign rawBits = raw;

    // one sample history per button
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                history[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                history[i] <= {history[i][DEBOUNCE_DEPTH-2:0], rawBits[i]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            filtered[i] = &history[i];
        end
    end

    // rising edge of the filtered level
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            filteredDly <= '0;
            pulse       <= '0;
        end else begin
            filteredDly <= filtered;
            pulse       <= filtered & ~filteredDly;
        end
    end

    assign pressed = pulse;

endmodule

/* vendingPkg.sv */
package vendingPkg;

    typedef logic [6:0] credit_t;

    // panel buttons, used for raw levels and for pulses
    typedef struct packed {
        logic coinSmall;
        logic coinMid;
        logic coinLarge;
        logic cancel;
    } buttonSet_t;

    // one bit per product, bit 0 is the 20 product
    typedef logic [3:0] productMask_t;

    typedef struct packed {
        logic       valid;
        logic       released;
        logic       extended;
        logic [7:0] code;
    } keyEvent_t;

    // 0 to 9, or DIGIT_BLANK
    typedef logic [3:0] digitCode_t;

    localparam digitCode_t DIGIT_BLANK = 4'd10;

    typedef struct packed {
        digitCode_t d3;
        digitCode_t d2;
        digitCode_t d1;
        digitCode_t d0;
    } displayDigits_t;

endpackage

/* vendingMachine_cfg.svh */
`ifndef VENDINGMACHINE_CFG_SVH
`define VENDINGMACHINE_CFG_SVH

// product prices, bit 0 is the cheapest product
`define PRICE_P0 20
`define PRICE_P1 25
`define PRICE_P2 30
`define PRICE_P3 80

`define COIN_SMALL 5
`define COIN_MID 10
`define COIN_LARGE 50
`define CREDIT_MAX 100
`define REFUND_STEP 5

// default timing, 100 MHz board clock
`define DEBOUNCE_DEPTH_DEFAULT 4
`define REFUND_TICKS_DEFAULT 100000000
`define SCAN_TICKS_DEFAULT 50000

// PS/2 set 2 scan codes
`define SCAN_A 8'h1C
`define SCAN_S 8'h1B
`define SCAN_D 8'h23
`define SCAN_F 8'h2B
`define SCAN_BREAK 8'hF0
`define SCAN_EXTENDED 8'hE0

`endif
